//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= dcache_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+common
common/dcache_pkg.sv
src/lsu_align.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
src/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_checker.sv
bench/dcache_tb.sv

//--- bench/dcache_checker.sv
`timescale 1ns/100ps

`include "dcache_defines.svh"

module dcache_checker
    import dcache_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input cpu_req_t req,
    input logic     stall,
    input mem_req_t mem_req,
    input logic [1:0] state
);

    // encoding of REFILL in the controller
    localparam logic [1:0] ST_REFILL = 2'd2;

    int unsigned stall_run;
    logic        uncached_acc;

    assign uncached_acc = (req.rd || req.wr)
        && (req.addr.mmio.region == `DCACHE_MMIO_REGION);

    // stall cycles seen before the current one
    always @(posedge clk) begin
        if (rst || !stall) begin
            stall_run <= 0;
        end else begin
            stall_run <= stall_run + 1;
        end
    end

    stall_len: assert property (@(posedge clk) disable iff (rst) stall |-> stall_run < 2)
        else $error("stall held for more than 2 cycles");

    req_hold: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(req))
        else $error("req changed while stalled");

    no_we_refill: assert property (@(posedge clk) disable iff (rst)
        state == ST_REFILL |-> !mem_req.we)
        else $error("memory write during refill");

    mmio_no_stall: assert property (@(posedge clk) disable iff (rst) uncached_acc |-> !stall)
        else $error("stall on uncached access");

endmodule

bind dcache_top dcache_checker dcache_checker_inst (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .stall   (stall),
    .mem_req (mem_req),
    .state   (dcache_ctrl_inst.state)
);

//--- bench/dcache_mem_model.sv
`timescale 1ns/100ps

`include "dcache_defines.svh"

module dcache_mem_model
    import dcache_pkg::*;
(
    input  logic                      clk,
    input  mem_req_t                  mem_req,
    output logic [`DCACHE_DATA_W-1:0] rdata
);

    localparam int WORDS = 1 << 18;

    // word storage for byte address bits 19:2
    logic [`DCACHE_DATA_W-1:0] mem [WORDS];

    assign rdata = mem[mem_req.addr[19:2]];

    always @(posedge clk) begin
        if (mem_req.we) begin
            mem[mem_req.addr[19:2]] <= mem_req.wdata;
        end
    end

endmodule

//--- bench/dcache_tb.sv
`timescale 1ns/100ps

`include "dcache_defines.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam int WORDS = 1 << 18;
    localparam int STALL_LIMIT = 8;

    logic      clk;
    logic      rst;
    cpu_req_t  req;
    logic [31:0] load_data;
    logic      stall;
    mem_req_t  mem_req;
    logic [31:0] mem_rdata;

    logic [31:0] shadow [WORDS];
    integer      seed;
    int          checks;
    int          errors;

    // values handed to the compare process
    event        check_ev;
    logic        chk_data;
    logic [31:0] exp_data;
    logic [31:0] got_data;
    int          exp_stalls;
    int          got_stalls;

    dcache_top dcache_top_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .load_data (load_data),
        .stall     (stall),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    dcache_mem_model dcache_mem_model_inst (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [17:0] w);
        return ({14'h0, w} * 32'h9e37_79b9) ^ {w[13:0], w};
    endfunction

    function automatic logic [31:0] ref_load(input ldst_op_e op, input logic [1:0] off,
                                             input logic [31:0] word);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (op)
            LH: return {{16{sh[15]}}, sh[15:0]};
            LHU: return {16'h0, sh[15:0]};
            LB: return {{24{sh[7]}}, sh[7:0]};
            LBU: return {24'h0, sh[7:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] ref_store(input ldst_op_e op, input logic [1:0] off,
                                              input logic [31:0] word, input logic [31:0] wd);
        logic [31:0] mask;
        case (op)
            SH: mask = 32'h0000_ffff << (8 * off);
            SB: mask = 32'h0000_00ff << (8 * off);
            default: mask = 32'hffff_ffff;
        endcase
        return (word & ~mask) | ((wd << (8 * off)) & mask);
    endfunction

    always @(check_ev) begin
        checks = checks + 1;
        if (chk_data && got_data !== exp_data) begin
            errors = errors + 1;
            $display("** Error at %0t: data %h, expected %h", $time, got_data, exp_data);
        end
        if (exp_stalls >= 0 && got_stalls != exp_stalls) begin
            errors = errors + 1;
            $display("** Error at %0t: %0d stall cycles, expected %0d",
                     $time, got_stalls, exp_stalls);
        end
    end

    // one request held until stall drops
    task automatic access(input ldst_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] data,
                          output int stalls);
        req.addr  = addr;
        req.wdata = wdata;
        req.op    = op;
        req.rd    = (op inside {LW, LH, LHU, LB, LBU});
        req.wr    = !req.rd;
        stalls    = 0;
        #1;
        while (stall) begin
            stalls = stalls + 1;
            if (stalls > STALL_LIMIT) begin
                $display("timeout: stall stayed high for %0d cycles at %0t", stalls, $time);
                $display("STATUS: FAIL");
                $finish;
            end else begin
                @(posedge clk);
                #2;
            end
        end
        data = load_data;
        @(posedge clk);
        #1;
        req.rd = 1'b0;
        req.wr = 1'b0;
    endtask

    task automatic load_check(input ldst_op_e op, input logic [31:0] addr, input int n_stall);
        logic [31:0] d;
        int          s;
        access(op, addr, 32'h0, d, s);
        chk_data   = 1'b1;
        got_data   = d;
        exp_data   = ref_load(op, addr[1:0], shadow[addr[19:2]]);
        got_stalls = s;
        exp_stalls = n_stall;
        ->check_ev;
    endtask

    task automatic store_do(input ldst_op_e op, input logic [31:0] addr,
                            input logic [31:0] wd, input int n_stall);
        logic [31:0] d;
        int          s;
        access(op, addr, wd, d, s);
        if (addr[19:16] == `DCACHE_MMIO_REGION) begin
            shadow[addr[19:2]] = wd;
        end else begin
            shadow[addr[19:2]] = ref_store(op, addr[1:0], shadow[addr[19:2]], wd);
        end
        chk_data   = 1'b0;
        got_stalls = s;
        exp_stalls = n_stall;
        ->check_ev;
    endtask

    function automatic logic [31:0] cached_addr(input logic [7:0] tag, input logic [9:0] idx,
                                                input logic [1:0] off);
        return {12'h0, tag, idx, off};
    endfunction

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] m;
        logic [1:0]  off;
        ldst_op_e    op;
        int          r;

        seed      = 32'h7b1b_f0d8;
        checks    = 0;
        errors    = 0;
        clk       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        chk_data  = 1'b0;
        exp_data  = '0;
        got_data  = '0;
        exp_stalls = -1;
        got_stalls = 0;
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = fill_word(i[17:0]);
            dcache_mem_model_inst.mem[i] = shadow[i];
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        #1;
        if (stall !== 1'b0 || mem_req.we !== 1'b0) begin
            errors = errors + 1;
            $display("** Error at %0t: stall or mem we high after reset", $time);
        end

        // first load misses clean and the repeat hits
        a = cached_addr(8'h12, 10'h040, 2'b00);
        load_check(LW, a, 1);
        load_check(LW, a, 0);

        // every load op at every legal offset
        for (int k = 0; k < 4; k++) begin
            a = cached_addr(8'h20 + k[7:0], 10'h100 + k[9:0], 2'b00);
            store_do(SW, a, $random(seed), 1);
            load_check(LW, a, 0);
            for (int o = 0; o < 4; o++) begin
                load_check(LB, a | o, 0);
                load_check(LBU, a | o, 0);
            end
            for (int o = 0; o < 4; o += 2) begin
                load_check(LH, a | o, 0);
                load_check(LHU, a | o, 0);
            end
        end

        // store merge
        a = cached_addr(8'h33, 10'h200, 2'b00);
        store_do(SB, a | 1, $random(seed), 1);
        load_check(LW, a, 0);
        store_do(SH, a | 2, $random(seed), 0);
        load_check(LW, a, 0);
        store_do(SB, a | 3, $random(seed), 0);
        store_do(SW, a, $random(seed), 0);
        load_check(LW, a, 0);

        // dirty eviction by another tag at the same index
        b = cached_addr(8'h34, 10'h200, 2'b00);
        load_check(LW, b, 2);
        if (dcache_mem_model_inst.mem[a[19:2]] !== shadow[a[19:2]]) begin
            errors = errors + 1;
            $display("** Error at %0t: written back word %h, expected %h", $time,
                     dcache_mem_model_inst.mem[a[19:2]], shadow[a[19:2]]);
        end
        load_check(LW, b, 0);
        load_check(LW, a, 1);

        // mmio window never stalls
        a = {12'h0, 4'hf, 16'h0010};
        store_do(SW, a, $random(seed), 0);
        if (dcache_mem_model_inst.mem[a[19:2]] !== shadow[a[19:2]]) begin
            errors = errors + 1;
            $display("** Error at %0t: mmio store missing in memory", $time);
        end
        load_check(LW, a, 0);
        m = $random(seed);
        dcache_mem_model_inst.mem[a[19:2]] = m;
        shadow[a[19:2]] = m;
        load_check(LW, a, 0);
        load_check(LB, a | 3, 0);
        load_check(LHU, a | 2, 0);

        // random traffic over a few conflicting lines
        for (int n = 0; n < 300; n++) begin
            r   = $random(seed);
            op  = ldst_op_e'(r[2:0]);
            off = r[4:3];
            if (op == LW || op == SW) begin
                off = 2'b00;
            end else if (op inside {LH, LHU, SH}) begin
                off[0] = 1'b0;
            end
            a = cached_addr({6'h0, r[6:5]}, {7'h0, r[9:7]}, off);
            if (op inside {SW, SH, SB}) begin
                store_do(op, a, $random(seed), -1);
            end else begin
                load_check(op, a, -1);
            end
        end

        @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- common/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// word and address width
`define DCACHE_DATA_W 32

// 1024 one-word lines
`define DCACHE_INDEX_W 10
`define DCACHE_TAG_W 8

// address bits 19:16 of the uncached window
`define DCACHE_MMIO_REGION 4'hf

`endif

//--- common/dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

    typedef enum logic [3:0] {
        LW,
        LH,
        LHU,
        LB,
        LBU,
        SW,
        SH,
        SB
    } ldst_op_e;

    // byte address as seen by the cache
    typedef struct packed {
        logic [`DCACHE_DATA_W-`DCACHE_TAG_W-`DCACHE_INDEX_W-3:0] unused;
        logic [`DCACHE_TAG_W-1:0]                                tag;
        logic [`DCACHE_INDEX_W-1:0]                              index;
        logic [1:0]                                              offset;
    } cache_addr_t;

    // same word as seen by the mmio decoder
    typedef struct packed {
        logic [`DCACHE_DATA_W-21:0] unused;
        logic [3:0]                 region;
        logic [15:0]                reg_off;
    } mmio_addr_t;

    typedef union packed {
        cache_addr_t cache;
        mmio_addr_t  mmio;
    } dcache_addr_u;

    typedef struct packed {
        dcache_addr_u             addr;
        logic [`DCACHE_DATA_W-1:0] wdata;
        ldst_op_e                 op;
        logic                     rd;
        logic                     wr;
    } cpu_req_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`DCACHE_TAG_W-1:0]  tag;
        logic [`DCACHE_DATA_W-1:0] data;
    } line_t;

    typedef struct packed {
        logic [`DCACHE_DATA_W-1:0] addr;
        logic [`DCACHE_DATA_W-1:0] wdata;
        logic                     we;
    } mem_req_t;

endpackage

//--- dcache/dcache_array.sv
`timescale 1ns/100ps

`include "dcache_defines.svh"

module dcache_array
    import dcache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`DCACHE_INDEX_W-1:0] index,
    output line_t                      line_rd,
    input  logic                       line_we,
    input  line_t                      line_wr
);

    localparam int DEPTH = 1 << `DCACHE_INDEX_W;

    // dirty, tag and data per line
    logic [$bits(line_t)-2:0] entry_mem [DEPTH];
    logic [DEPTH-1:0]         valid_q;

    assign line_rd = {valid_q[index], entry_mem[index]};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (line_we) begin
            valid_q[index] <= line_wr.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            entry_mem[index] <= {line_wr.dirty, line_wr.tag, line_wr.data};
        end
    end

endmodule

//--- dcache/dcache_ctrl.sv
`timescale 1ns/100ps

`include "dcache_defines.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  cpu_req_t                   req,
    input  line_t                      line_rd,
    input  logic [`DCACHE_DATA_W-1:0]  mem_rdata,
    input  logic [`DCACHE_DATA_W-1:0]  store_word,
    output logic [`DCACHE_INDEX_W-1:0] index,
    output logic                       line_we,
    output line_t                      line_wr,
    output logic [`DCACHE_DATA_W-1:0]  align_src,
    output logic                       stall,
    output mem_req_t                   mem_req
);

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL
    } state_e;

    state_e state;
    logic   refill_pend;
    logic   access;
    logic   uncached;
    logic   cached_acc;
    logic   hit;
    logic   dirty_victim;

    assign index        = req.addr.cache.index;
    assign access       = req.rd || req.wr;
    assign uncached     = (req.addr.mmio.region == `DCACHE_MMIO_REGION);
    assign cached_acc   = access && !uncached;
    assign hit          = line_rd.valid && (line_rd.tag == req.addr.cache.tag);
    assign dirty_victim = line_rd.valid && line_rd.dirty;

    // first miss cycle is decoded from the line, refill after writeback is held in a flop
    always_comb begin
        if (refill_pend) begin
            state = REFILL;
        end else if (cached_acc && !hit) begin
            state = dirty_victim ? WRITEBACK : REFILL;
        end else begin
            state = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            refill_pend <= 1'b0;
        end else begin
            refill_pend <= (state == WRITEBACK);
        end
    end

    assign stall = (state != IDLE);

    // refill and uncached traffic both come from memory
    assign align_src = (state == REFILL || uncached) ? mem_rdata : line_rd.data;

    always_comb begin
        line_we = 1'b0;
        line_wr = '{valid: 1'b1, dirty: 1'b1, tag: req.addr.cache.tag, data: store_word};
        if (state == REFILL) begin
            line_we = 1'b1;
            line_wr = '{valid: 1'b1, dirty: 1'b0, tag: req.addr.cache.tag, data: mem_rdata};
        end else if (state == IDLE && cached_acc && req.wr) begin
            line_we = 1'b1;
        end
    end

    always_comb begin
        case (state)
            WRITEBACK: begin
                // victim address rebuilt from old tag and index
                mem_req.addr  = '0;
                mem_req.addr[`DCACHE_TAG_W+`DCACHE_INDEX_W+1:2] = {line_rd.tag, index};
                mem_req.wdata = line_rd.data;
                mem_req.we    = 1'b1;
            end
            REFILL: begin
                mem_req.addr  = {req.addr[`DCACHE_DATA_W-1:2], 2'b00};
                mem_req.wdata = req.wdata;
                mem_req.we    = 1'b0;
            end
            default: begin
                mem_req.addr  = req.addr;
                mem_req.wdata = req.wdata;
                mem_req.we    = uncached && req.wr;
            end
        endcase
    end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/100ps

`include "dcache_defines.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  cpu_req_t                  req,
    output logic [`DCACHE_DATA_W-1:0] load_data,
    output logic                      stall,
    output mem_req_t                  mem_req,
    input  logic [`DCACHE_DATA_W-1:0] mem_rdata
);

    logic [`DCACHE_INDEX_W-1:0] index;
    logic                       line_we;
    line_t                      line_wr;
    line_t                      line_rd;
    logic [`DCACHE_DATA_W-1:0]  align_src;
    logic [`DCACHE_DATA_W-1:0]  store_word;

    dcache_ctrl dcache_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .line_rd    (line_rd),
        .mem_rdata  (mem_rdata),
        .store_word (store_word),
        .index      (index),
        .line_we    (line_we),
        .line_wr    (line_wr),
        .align_src  (align_src),
        .stall      (stall),
        .mem_req    (mem_req)
    );

    dcache_array dcache_array_inst (
        .clk     (clk),
        .rst     (rst),
        .index   (index),
        .line_rd (line_rd),
        .line_we (line_we),
        .line_wr (line_wr)
    );

    lsu_align lsu_align_inst (
        .req        (req),
        .src_word   (align_src),
        .load_data  (load_data),
        .store_word (store_word)
    );

endmodule

//--- src/lsu_align.sv
`timescale 1ns/100ps

`include "dcache_defines.svh"

module lsu_align
    import dcache_pkg::*;
(
    input  cpu_req_t                  req,
    input  logic [`DCACHE_DATA_W-1:0] src_word,
    output logic [`DCACHE_DATA_W-1:0] load_data,
    output logic [`DCACHE_DATA_W-1:0] store_word
);

    logic [1:0]  offset;
    logic [15:0] half_sel;
    logic [7:0]  byte_sel;

    assign offset = req.addr.cache.offset;

    // lane pick for sub-word loads
    always_comb begin
        half_sel = offset[1] ? src_word[31:16] : src_word[15:0];
        case (offset)
            2'b00: byte_sel = src_word[7:0];
            2'b01: byte_sel = src_word[15:8];
            2'b10: byte_sel = src_word[23:16];
            default: byte_sel = src_word[31:24];
        endcase
    end

    always_comb begin
        case (req.op)
            LH: begin
                load_data = {{16{half_sel[15]}}, half_sel};
            end
            LHU: begin
                load_data = {16'h0000, half_sel};
            end
            LB: begin
                load_data = {{24{byte_sel[7]}}, byte_sel};
            end
            LBU: begin
                load_data = {24'h000000, byte_sel};
            end
            default: begin
                load_data = src_word;
            end
        endcase
    end

    // merge store data into the current word
    always_comb begin
        store_word = src_word;
        case (req.op)
            SW: begin
                store_word = req.wdata;
            end
            SH: begin
                if (offset[1]) begin
                    store_word[31:16] = req.wdata[15:0];
                end else begin
                    store_word[15:0] = req.wdata[15:0];
                end
            end
            SB: begin
                case (offset)
                    2'b00: store_word[7:0] = req.wdata[7:0];
                    2'b01: store_word[15:8] = req.wdata[7:0];
                    2'b10: store_word[23:16] = req.wdata[7:0];
                    default: store_word[31:24] = req.wdata[7:0];
                endcase
            end
            default: begin
                store_word = src_word;
            end
        endcase
    end

endmodule
